//--- vlog.f
rtl/rvPkg.sv
rtl/rvAlu.sv
rtl/rvRegFile.sv
rtl/rvBranchPredictor.sv
rtl/rvHazardUnit.sv
rtl/rvController.sv
rtl/rvDatapath.sv
rtl/rvCore.sv
verif/rvCoreTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = rvCoreTb
FILELIST = vlog.f
OBJDIR   = obj_dir
PASS     = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- verif/rvCoreTb.sv
module rvCoreTb import rvPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] PcStart    = 32'h0;
    localparam logic [31:0] MarkerAddr = 32'h3fc;   // Last store of every program
    localparam logic [31:0] Seed       = 32'hb1b0f05b;

    logic        clk;
    logic        reset;
    logic [31:0] pcF, instrF, dataAddrM, writeDataM, readDataM;
    logic        memWriteM;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] lcgState;
    string       testName;
    int          progLen;
    int          storeCount;
    logic        markerSeen;

    rvCore #(.PcStart(PcStart), .BtbEntries(32), .GhrBits(5)) i_rvCore (
        .clk(clk), .reset(reset),
        .PcF_o(pcF), .InstrF_i(instrF),
        .DataAddrM_o(dataAddrM), .WriteDataM_o(writeDataM),
        .MemWriteM_o(memWriteM), .ReadDataM_i(readDataM)
    );

    // Both memories read combinationally
    assign instrF    = imem[pcF[9:2]];
    assign readDataM = dmem[dataAddrM[9:2]];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (memWriteM === 1'b1)
            dmem[dataAddrM[9:2]] <= writeDataM;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] fillWord(logic [31:0] idx);
        return (idx * 32'h9e3779b1) ^ 32'hc3a50f1e;
    endfunction

    task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: %s expected %h actual %h", testName, what, expected, actual);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Instruction encoders
    function automatic logic [31:0] rType(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OpR};
    endfunction

    function automatic logic [31:0] iType(opcodeT op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(int rs2, int rs1, int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OpStore};
    endfunction

    function automatic logic [31:0] bType(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OpBranch};
    endfunction

    function automatic logic [31:0] jType(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OpJal};
    endfunction

    function automatic logic [31:0] uType(int rd, int upper);
        return {upper[19:0], rd[4:0], OpLui};
    endfunction

    task automatic emit(logic [31:0] instr);
        imem[progLen] = instr;
        progLen++;
    endtask

    task automatic loadConst(int rd);
        logic [31:0] rnd;
        rnd = nextRand();
        emit(uType(rd, rnd >> 12));   // lui then dependent addi
        emit(iType(OpI, 0, rd, rd, rnd & 32'hfff));
    endtask

    task automatic endProgram();
        emit(sType(1, 0, MarkerAddr));
        emit(jType(0, 0));   // Spin here
    endtask

    task automatic loadProgram(int testIdx);
        logic [31:0] rnd;
        int rd, rs1, rs2, f3, kind, off, n;
        for (int i = 0; i < 256; i++)
            imem[i] = 32'd0;
        progLen = 0;
        emit(iType(OpI, 0, 1, 0, 32'h100));   // x1 is the store base
        case (testIdx)
            2: begin
                for (int r = 5; r <= 12; r++)
                    loadConst(r);
                rs1 = 5;
                for (int k = 0; k < 12; k++) begin
                    rnd  = nextRand();
                    kind = rnd % 5;
                    rd   = 7 + (rnd >> 4) % 6;
                    rs2  = 5 + (rnd >> 8) % 8;
                    case (kind)
                        2: f3 = 7;
                        3: f3 = 6;
                        4: f3 = 2;
                        default: f3 = 0;
                    endcase
                    if (rnd[16] && kind != 1)
                        emit(iType(OpI, f3, rd, rs1, rnd >> 20));
                    else
                        emit(rType(kind == 1 ? 32 : 0, f3, rd, rs1, rs2));
                    emit(sType(rd, 1, 4 * k));   // Data forwarded from M
                    rs1 = rd;                    // Next op reads it from WB
                end
            end
            3: begin
                emit(iType(OpI, 0, 2, 0, 32'h200));
                loadConst(7);
                for (int k = 0; k < 6; k++) begin
                    off = (nextRand() % 64) * 4;
                    emit(iType(OpLoad, 2, 5, 1, off));
                    if (k % 2 == 0) begin
                        emit(rType(0, 0, 6, 5, 7));
                        emit(sType(6, 2, 4 * k));
                    end else begin
                        emit(sType(5, 2, 4 * k));
                    end
                end
            end
            4: begin
                n = 5 + nextRand() % 6;
                emit(iType(OpI, 0, 5, 0, 0));
                emit(iType(OpI, 0, 6, 0, n));
                emit(iType(OpI, 0, 7, 0, 0));
                emit(iType(OpI, 0, 5, 5, 1));   // Loop body
                emit(rType(0, 0, 7, 7, 5));
                emit(sType(7, 1, 0));
                emit(iType(OpI, 0, 1, 1, 4));
                emit(bType(1, 5, 6, -16));
                emit(sType(5, 0, 32'h300));     // Final count
            end
            5: begin
                emit(iType(OpI, 0, 2, 0, 32'h200));
                loadConst(5);
                emit(iType(OpI, 0, 6, 5, 0));   // x6 equals x5
                loadConst(7);
                emit(iType(OpI, 0, 9, 0, 32'h5a));
                emit(iType(OpI, 0, 10, 0, 0));
                for (int k = 0; k < 8; k++) begin
                    rs2 = nextRand() % 2 == 0 ? 6 : 7;
                    emit(bType(0, 5, rs2, 12));
                    emit(sType(9, 1, 8 * k));       // Shadow slots
                    emit(sType(9, 1, 8 * k + 4));
                    emit(iType(OpI, 0, 10, 10, 1));
                    emit(sType(10, 2, 4 * k));
                end
            end
            6: begin
                emit(uType(3, nextRand() >> 12));
                emit(sType(3, 1, 0));
                emit(jType(4, 28));             // Call subroutine at word 10
                emit(sType(4, 1, 4));
                emit(sType(8, 1, 8));
                emit(jType(4, 16));
                emit(sType(4, 1, 12));
                emit(sType(8, 1, 16));
                emit(jType(0, 16));             // Skip over the subroutine
                emit(uType(7, nextRand() >> 12));
                emit(sType(7, 1, 20));
                emit(iType(OpJalr, 0, 8, 4, 0));
            end
            default: ;
        endcase
        endProgram();
    endtask

    // Instruction-set model, fills the expected store list
    function automatic int runModel();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc, nextPc, instr, a, b, res, addr;
        logic [31:0] immI, immS, immB, immJ;
        logic        wr;
        int          count;
        for (int i = 0; i < 32; i++)
            regs[i] = 32'd0;
        for (int i = 0; i < 256; i++)
            mem[i] = fillWord(i);
        expAddr.delete();
        expData.delete();
        pc    = PcStart;
        count = 0;
        while (count < 4096) begin
            instr  = imem[pc[9:2]];
            count++;
            a      = regs[instr[19:15]];
            b      = regs[instr[24:20]];
            immI   = {{20{instr[31]}}, instr[31:20]};
            immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            nextPc = pc + 32'd4;
            wr     = 1'b0;
            res    = 32'd0;
            case (instr[6:0])
                OpR, OpI: begin
                    wr = 1'b1;
                    if (instr[6:0] == OpI)
                        b = immI;
                    case (instr[14:12])
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b110:  res = a | b;
                        3'b111:  res = a & b;
                        default: res = (instr[6:0] == OpR && instr[30]) ? a - b : a + b;
                    endcase
                end
                OpLoad: begin
                    addr = a + immI;
                    res  = mem[addr[9:2]];
                    wr   = 1'b1;
                end
                OpStore: begin
                    addr = a + immS;
                    mem[addr[9:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    if (addr == MarkerAddr)
                        return count;
                end
                OpBranch: begin
                    if ((a == b) != instr[12])   // funct3 bit 0 means bne
                        nextPc = pc + immB;
                end
                OpJal: begin
                    wr     = 1'b1;
                    res    = pc + 32'd4;
                    nextPc = pc + immJ;
                end
                OpJalr: begin
                    wr     = 1'b1;
                    res    = pc + 32'd4;
                    nextPc = (a + immI) & ~32'd1;
                end
                OpLui: begin
                    wr  = 1'b1;
                    res = {instr[31:12], 12'd0};
                end
                default: ;
            endcase
            if (wr && instr[11:7] != 5'd0)
                regs[instr[11:7]] = res;
            pc = nextPc;
        end
        return count;
    endfunction

    // Store comparator, sampled away from the active edge
    always @(negedge clk) begin
        if (!reset && memWriteM === 1'b1) begin
            if (expAddr.size() == 0) begin
                $display("%s: store to %h after the model's last store", testName, dataAddrM);
                $display("Test failed");
                $fatal(1, "Unexpected store");
            end else begin
                checkValue("store address", expAddr[0], dataAddrM);
                checkValue("store data", expData[0], writeDataM);
                if (expAddr[0] == MarkerAddr)
                    markerSeen = 1'b1;
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                storeCount++;
            end
        end
    end

    task automatic runTest(string name, int testIdx);
        int modelCount;
        int expCount;
        int limit;
        int cycles;
        testName = name;
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        checkValue("MemWrite in reset", 32'd0, {31'd0, memWriteM});
        loadProgram(testIdx);
        for (int i = 0; i < 256; i++)
            dmem[i] = fillWord(i);
        modelCount = runModel();
        expCount   = expAddr.size();
        storeCount = 0;
        markerSeen = 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("PC after reset", PcStart, pcF);
        checkValue("MemWrite after reset", 32'd0, {31'd0, memWriteM});
        limit  = modelCount * 4 + 20;
        cycles = 0;
        while (!markerSeen && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!markerSeen) begin
            $display("Timeout: %s did not reach its final store within %0d cycles", name, limit);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
        checkValue("store count", expCount, storeCount);
        $display("%s: %0d stores matched in %0d cycles", name, storeCount, cycles);
    endtask

    initial begin
        reset      = 1'b1;
        lcgState   = Seed;
        markerSeen = 1'b0;
        storeCount = 0;
        runTest("reset", 1);
        runTest("alu forwarding", 2);
        runTest("load use", 3);
        runTest("counted loop", 4);
        runTest("forward beq", 5);
        runTest("jal jalr lui", 6);
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- rtl/rvCore.sv
module rvCore import rvPkg::*; #(
    parameter logic [31:0] PcStart    = 32'h0,
    parameter int          BtbEntries = 32,
    parameter int          GhrBits    = 5
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] PcF_o,
    input  logic [31:0] InstrF_i,
    output logic [31:0] DataAddrM_o,
    output logic [31:0] WriteDataM_o,
    output logic        MemWriteM_o,
    input  logic [31:0] ReadDataM_i
);

    opcodeT    op;
    logic [2:0] funct3;
    logic      funct7b5;
    immSrcT    immSrcD;
    aluOpT     aluControlE;
    logic      aluSrcE, branchE, jumpE, jalrE;
    resultSrcT resultSrcE, resultSrcM, resultSrcW;
    logic      regWriteM, regWriteW;
    logic      stallF, stallD, flushD, flushE, mispredictE;
    forwardT   forwardAE, forwardBE;
    logic [4:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

    rvDatapath #(
        .PcStart(PcStart), .BtbEntries(BtbEntries), .GhrBits(GhrBits)
    ) i_rvDatapath (
        .clk(clk), .reset(reset),
        .StallF_i(stallF), .StallD_i(stallD), .FlushD_i(flushD), .FlushE_i(flushE),
        .PcF_o(PcF_o), .InstrF_i(InstrF_i),
        .Op_o(op), .Funct3_o(funct3), .Funct7b5_o(funct7b5),
        .ImmSrcD_i(immSrcD), .ALUControlE_i(aluControlE), .ALUSrcE_i(aluSrcE),
        .BranchE_i(branchE), .JumpE_i(jumpE), .JalrE_i(jalrE),
        .ForwardAE_i(forwardAE), .ForwardBE_i(forwardBE),
        .ResultSrcM_i(resultSrcM), .ResultSrcW_i(resultSrcW), .RegWriteW_i(regWriteW),
        .Rs1D_o(rs1D), .Rs2D_o(rs2D), .Rs1E_o(rs1E), .Rs2E_o(rs2E),
        .RdE_o(rdE), .RdM_o(rdM), .RdW_o(rdW),
        .MispredictE_o(mispredictE),
        .ALUResultM_o(DataAddrM_o), .WriteDataM_o(WriteDataM_o), .ReadDataM_i(ReadDataM_i)
    );

    rvController i_rvController (
        .clk(clk), .reset(reset),
        .Op_i(op), .Funct3_i(funct3), .Funct7b5_i(funct7b5), .FlushE_i(flushE),
        .ImmSrcD_o(immSrcD), .ALUControlE_o(aluControlE), .ALUSrcE_o(aluSrcE),
        .BranchE_o(branchE), .JumpE_o(jumpE), .JalrE_o(jalrE),
        .ResultSrcE_o(resultSrcE), .ResultSrcM_o(resultSrcM), .ResultSrcW_o(resultSrcW),
        .RegWriteM_o(regWriteM), .RegWriteW_o(regWriteW), .MemWriteM_o(MemWriteM_o)
    );

    rvHazardUnit i_rvHazardUnit (
        .Rs1D_i(rs1D), .Rs2D_i(rs2D), .Rs1E_i(rs1E), .Rs2E_i(rs2E),
        .RdE_i(rdE), .RdM_i(rdM), .RdW_i(rdW),
        .ResultSrcE_i(resultSrcE), .RegWriteM_i(regWriteM), .RegWriteW_i(regWriteW),
        .MispredictE_i(mispredictE),
        .StallF_o(stallF), .StallD_o(stallD), .FlushD_o(flushD), .FlushE_o(flushE),
        .ForwardAE_o(forwardAE), .ForwardBE_o(forwardBE)
    );

    // Only word accesses are supported
    assert property (@(posedge clk) disable iff (reset) MemWriteM_o |-> DataAddrM_o[1:0] == 2'b00)
        else $error("Misaligned store to %h", DataAddrM_o);

endmodule

//--- rtl/rvDatapath.sv
module rvDatapath import rvPkg::*; #(
    parameter logic [31:0] PcStart    = 32'h0,
    parameter int          BtbEntries = 32,
    parameter int          GhrBits    = 5
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         StallF_i,
    input  logic         StallD_i,
    input  logic         FlushD_i,
    input  logic         FlushE_i,
    output logic [31:0]  PcF_o,
    input  logic [31:0]  InstrF_i,
    output opcodeT       Op_o,
    output logic [2:0]   Funct3_o,
    output logic         Funct7b5_o,
    input  immSrcT       ImmSrcD_i,
    input  aluOpT        ALUControlE_i,
    input  logic         ALUSrcE_i,
    input  logic         BranchE_i,
    input  logic         JumpE_i,
    input  logic         JalrE_i,
    input  forwardT      ForwardAE_i,
    input  forwardT      ForwardBE_i,
    input  resultSrcT    ResultSrcM_i,
    input  resultSrcT    ResultSrcW_i,
    input  logic         RegWriteW_i,
    output logic [4:0]   Rs1D_o,
    output logic [4:0]   Rs2D_o,
    output logic [4:0]   Rs1E_o,
    output logic [4:0]   Rs2E_o,
    output logic [4:0]   RdE_o,
    output logic [4:0]   RdM_o,
    output logic [4:0]   RdW_o,
    output logic         MispredictE_o,
    output logic [31:0]  ALUResultM_o,
    output logic [31:0]  WriteDataM_o,
    input  logic [31:0]  ReadDataM_i
);

    logic [31:0] pcPlus4F, targetF, pcNextF;
    logic        takenF;
    logic [GhrBits-1:0] phtIndexF, phtIndexD, phtIndexE;
    logic [31:0] instrD, pcD, pcPlus4D, rd1D, rd2D, immD;
    logic        predTakenD, predTakenE;
    logic [4:0]  rdD;
    logic [31:0] rd1E, rd2E, pcE, pcPlus4E, immE;
    logic [2:0]  funct3E;
    logic [31:0] srcAE, srcBE, writeDataE, aluResultE, pcTargetE, redirectE, targetE;
    logic        zeroE, takenE;
    logic [31:0] pcPlus4M, immM, forwardDataM;
    logic [31:0] aluResultW, readDataW, pcPlus4W, immW, resultW;

    // Fetch, prediction steers the PC unless execute redirects
    assign pcPlus4F = PcF_o + 32'd4;
    assign pcNextF  = MispredictE_o ? redirectE : (takenF ? targetF : pcPlus4F);

    always_ff @(posedge clk) begin
        if (reset)
            PcF_o <= PcStart;
        else if (!StallF_i)
            PcF_o <= pcNextF;
    end

    rvBranchPredictor #(.BtbEntries(BtbEntries), .GhrBits(GhrBits)) i_rvBranchPredictor (
        .clk(clk), .reset(reset),
        .PcF_i(PcF_o), .TakenF_o(takenF), .TargetF_o(targetF), .PhtIndexF_o(phtIndexF),
        .UpdateE_i(BranchE_i | JumpE_i), .IsBranchE_i(BranchE_i), .TakenE_i(takenE),
        .PhtIndexE_i(phtIndexE), .PcE_i(pcE), .TargetE_i(targetE)
    );

    // Decode
    always_ff @(posedge clk) begin
        if (reset || FlushD_i) begin
            instrD     <= 32'b0;   // Bubble
            predTakenD <= 1'b0;
        end else if (!StallD_i) begin
            instrD     <= InstrF_i;
            pcD        <= PcF_o;
            pcPlus4D   <= pcPlus4F;
            predTakenD <= takenF;
            phtIndexD  <= phtIndexF;
        end
    end

    assign Op_o       = opcodeT'(instrD[6:0]);
    assign Funct3_o   = instrD[14:12];
    assign Funct7b5_o = instrD[30];
    assign Rs1D_o     = instrD[19:15];
    assign Rs2D_o     = instrD[24:20];
    assign rdD        = instrD[11:7];

    rvRegFile i_rvRegFile (
        .clk(clk), .A1_i(Rs1D_o), .A2_i(Rs2D_o), .A3_i(RdW_o),
        .We3_i(RegWriteW_i), .Wd3_i(resultW), .Rd1_o(rd1D), .Rd2_o(rd2D)
    );

    always_comb begin
        unique case (ImmSrcD_i)
            ImmI:    immD = {{20{instrD[31]}}, instrD[31:20]};
            ImmS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            ImmB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            ImmJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            default: immD = {instrD[31:12], 12'b0};   // ImmU
        endcase
    end

    // Execute
    always_ff @(posedge clk) begin
        if (reset || FlushE_i) begin
            predTakenE <= 1'b0;
            Rs1E_o     <= 5'd0;
            Rs2E_o     <= 5'd0;
            RdE_o      <= 5'd0;
        end else begin
            predTakenE <= predTakenD;
            Rs1E_o     <= Rs1D_o;
            Rs2E_o     <= Rs2D_o;
            RdE_o      <= rdD;
        end
        rd1E      <= rd1D;
        rd2E      <= rd2D;
        pcE       <= pcD;
        pcPlus4E  <= pcPlus4D;
        immE      <= immD;
        funct3E   <= Funct3_o;
        phtIndexE <= phtIndexD;
    end

    function automatic logic [31:0] fwdMux(forwardT sel, logic [31:0] regVal,
                                           logic [31:0] memVal, logic [31:0] wbVal);
        case (sel)
            FwdMem:  return memVal;
            FwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcAE      = fwdMux(ForwardAE_i, rd1E, forwardDataM, resultW);
    assign writeDataE = fwdMux(ForwardBE_i, rd2E, forwardDataM, resultW);
    assign srcBE      = ALUSrcE_i ? immE : writeDataE;

    rvAlu i_rvAlu (
        .A_i(srcAE), .B_i(srcBE), .AluOp_i(ALUControlE_i),
        .Result_o(aluResultE), .Zero_o(zeroE)
    );

    // Branch resolution, funct3[0] selects bne
    assign pcTargetE     = pcE + immE;
    assign takenE        = JumpE_i | (BranchE_i & (zeroE ^ funct3E[0]));
    assign MispredictE_o = (takenE != predTakenE) | JalrE_i;
    assign targetE       = JalrE_i ? {aluResultE[31:1], 1'b0} : pcTargetE;
    assign redirectE     = (predTakenE && !takenE) ? pcPlus4E : targetE;

    // Memory
    always_ff @(posedge clk) begin
        ALUResultM_o <= aluResultE;
        WriteDataM_o <= writeDataE;
        pcPlus4M     <= pcPlus4E;
        immM         <= immE;
        RdM_o        <= RdE_o;
    end

    always_comb begin
        case (ResultSrcM_i)
            ResPcPlus4: forwardDataM = pcPlus4M;
            ResImm:     forwardDataM = immM;
            default:    forwardDataM = ALUResultM_o;   // Loads never forward from M
        endcase
    end

    // Writeback
    always_ff @(posedge clk) begin
        aluResultW <= ALUResultM_o;
        readDataW  <= ReadDataM_i;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
        RdW_o      <= RdM_o;
    end

    always_comb begin
        unique case (ResultSrcW_i)
            ResMem:     resultW = readDataW;
            ResPcPlus4: resultW = pcPlus4W;
            ResImm:     resultW = immW;
            default:    resultW = aluResultW;
        endcase
    end

endmodule

//--- rtl/rvController.sv
module rvController import rvPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  opcodeT    Op_i,
    input  logic [2:0] Funct3_i,
    input  logic      Funct7b5_i,
    input  logic      FlushE_i,
    output immSrcT    ImmSrcD_o,
    output aluOpT     ALUControlE_o,
    output logic      ALUSrcE_o,
    output logic      BranchE_o,
    output logic      JumpE_o,
    output logic      JalrE_o,
    output resultSrcT ResultSrcE_o,
    output resultSrcT ResultSrcM_o,
    output resultSrcT ResultSrcW_o,
    output logic      RegWriteM_o,
    output logic      RegWriteW_o,
    output logic      MemWriteM_o
);

    logic      regWriteD, memWriteD, aluSrcD, branchD, jumpD, jalrD, arithD;
    resultSrcT resultSrcD;
    aluOpT     aluControlD;
    logic      regWriteE, memWriteE;

    // Main decoder, zero instruction decodes to all control low
    always_comb begin
        {regWriteD, memWriteD, aluSrcD, branchD, jumpD, jalrD, arithD} = '0;
        resultSrcD = ResAlu;
        ImmSrcD_o  = ImmI;
        unique case (Op_i)
            OpR:      {regWriteD, arithD} = 2'b11;
            OpI:      {regWriteD, aluSrcD, arithD} = 3'b111;
            OpLoad: begin
                {regWriteD, aluSrcD} = 2'b11;
                resultSrcD = ResMem;
            end
            OpStore: begin
                {memWriteD, aluSrcD} = 2'b11;
                ImmSrcD_o = ImmS;
            end
            OpBranch: begin
                branchD   = 1'b1;
                ImmSrcD_o = ImmB;
            end
            OpJal: begin
                {regWriteD, jumpD} = 2'b11;
                resultSrcD = ResPcPlus4;
                ImmSrcD_o  = ImmJ;
            end
            OpJalr: begin
                {regWriteD, aluSrcD, jumpD, jalrD} = 4'b1111;
                resultSrcD = ResPcPlus4;
            end
            OpLui: begin
                regWriteD  = 1'b1;
                resultSrcD = ResImm;
                ImmSrcD_o  = ImmU;
            end
            default: ;
        endcase
    end

    // ALU decoder
    always_comb begin
        aluControlD = AluAdd;
        if (branchD)
            aluControlD = AluSub;   // Zero flag compares
        else if (arithD) begin
            case (Funct3_i)
                3'b000:  aluControlD = (Op_i == OpR && Funct7b5_i) ? AluSub : AluAdd;
                3'b010:  aluControlD = AluSlt;
                3'b110:  aluControlD = AluOr;
                3'b111:  aluControlD = AluAnd;
                default: aluControlD = AluAdd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || FlushE_i) begin
            {regWriteE, memWriteE, ALUSrcE_o, BranchE_o, JumpE_o, JalrE_o} <= '0;
            ResultSrcE_o  <= ResAlu;
            ALUControlE_o <= AluAdd;
        end else begin
            {regWriteE, memWriteE, ALUSrcE_o} <= {regWriteD, memWriteD, aluSrcD};
            {BranchE_o, JumpE_o, JalrE_o}     <= {branchD, jumpD, jalrD};
            ResultSrcE_o  <= resultSrcD;
            ALUControlE_o <= aluControlD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            {RegWriteM_o, MemWriteM_o, RegWriteW_o} <= '0;
            ResultSrcM_o <= ResAlu;
            ResultSrcW_o <= ResAlu;
        end else begin
            RegWriteM_o  <= regWriteE;
            MemWriteM_o  <= memWriteE;
            ResultSrcM_o <= ResultSrcE_o;
            RegWriteW_o  <= RegWriteM_o;
            ResultSrcW_o <= ResultSrcM_o;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        Op_i != opcodeT'(7'd0) |->
            Op_i inside {OpR, OpI, OpLoad, OpStore, OpBranch, OpJal, OpJalr, OpLui})
        else $error("Unsupported opcode %b in decode", Op_i);

endmodule

//--- rtl/rvHazardUnit.sv
module rvHazardUnit import rvPkg::*; (
    input  logic [4:0] Rs1D_i,
    input  logic [4:0] Rs2D_i,
    input  logic [4:0] Rs1E_i,
    input  logic [4:0] Rs2E_i,
    input  logic [4:0] RdE_i,
    input  logic [4:0] RdM_i,
    input  logic [4:0] RdW_i,
    input  resultSrcT  ResultSrcE_i,
    input  logic       RegWriteM_i,
    input  logic       RegWriteW_i,
    input  logic       MispredictE_i,
    output logic       StallF_o,
    output logic       StallD_o,
    output logic       FlushD_o,
    output logic       FlushE_o,
    output forwardT    ForwardAE_o,
    output forwardT    ForwardBE_o
);

    logic loadUse;

    // Memory stage holds the newer value
    function automatic forwardT fwdSel(logic [4:0] rs);
        if (rs != 5'd0 && rs == RdM_i && RegWriteM_i)
            return FwdMem;
        else if (rs != 5'd0 && rs == RdW_i && RegWriteW_i)
            return FwdWb;
        return FwdEx;
    endfunction

    always_comb ForwardAE_o = fwdSel(Rs1E_i);
    always_comb ForwardBE_o = fwdSel(Rs2E_i);

    assign loadUse  = (ResultSrcE_i == ResMem) && RdE_i != 5'd0
                      && (RdE_i == Rs1D_i || RdE_i == Rs2D_i);
    assign StallF_o = loadUse;
    assign StallD_o = loadUse;
    assign FlushD_o = MispredictE_i;
    assign FlushE_o = loadUse | MispredictE_i;

    // A load in execute can never be a mispredicted branch
    always_comb begin
        assert final (!(StallD_o && FlushD_o)) else $error("Decode stalled and flushed");
    end

endmodule

//--- rtl/rvBranchPredictor.sv
module rvBranchPredictor #(
    parameter int BtbEntries = 32,
    parameter int GhrBits    = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        PcF_i,
    output logic               TakenF_o,
    output logic [31:0]        TargetF_o,
    output logic [GhrBits-1:0] PhtIndexF_o,
    input  logic               UpdateE_i,
    input  logic               IsBranchE_i,
    input  logic               TakenE_i,
    input  logic [GhrBits-1:0] PhtIndexE_i,
    input  logic [31:0]        PcE_i,
    input  logic [31:0]        TargetE_i
);

    localparam int IdxBits = $clog2(BtbEntries);
    localparam int TagBits = 30 - IdxBits;

    logic [1:0]         pht [2**GhrBits];
    logic               btbValid [BtbEntries];
    logic               btbJump [BtbEntries];
    logic [TagBits-1:0] btbTag [BtbEntries];
    logic [31:0]        btbTarget [BtbEntries];
    logic [GhrBits-1:0] ghr;
    logic [IdxBits-1:0] idxF, idxE;
    logic               hitF;

    assign idxF        = PcF_i[IdxBits+1:2];
    assign idxE        = PcE_i[IdxBits+1:2];
    assign PhtIndexF_o = PcF_i[GhrBits+1:2] ^ ghr;   // gshare hash
    assign hitF        = btbValid[idxF] && btbTag[idxF] == PcF_i[31:IdxBits+2];
    assign TakenF_o    = hitF && (btbJump[idxF] || pht[PhtIndexF_o][1]);
    assign TargetF_o   = btbTarget[idxF];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < 2**GhrBits; i++)
                pht[i] <= 2'b01;   // Weakly not taken
            for (int i = 0; i < BtbEntries; i++)
                btbValid[i] <= 1'b0;
        end else if (UpdateE_i) begin
            if (IsBranchE_i) begin
                ghr <= {ghr[GhrBits-2:0], TakenE_i};
                if (TakenE_i && pht[PhtIndexE_i] != 2'b11)
                    pht[PhtIndexE_i] <= pht[PhtIndexE_i] + 2'b01;
                else if (!TakenE_i && pht[PhtIndexE_i] != 2'b00)
                    pht[PhtIndexE_i] <= pht[PhtIndexE_i] - 2'b01;
            end
            if (TakenE_i)
                btbValid[idxE] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (UpdateE_i && TakenE_i) begin
            btbJump[idxE]   <= !IsBranchE_i;
            btbTag[idxE]    <= PcE_i[31:IdxBits+2];
            btbTarget[idxE] <= TargetE_i;
        end
    end

endmodule

//--- rtl/rvRegFile.sv
module rvRegFile (
    input  logic        clk,
    input  logic [4:0]  A1_i,
    input  logic [4:0]  A2_i,
    input  logic [4:0]  A3_i,
    input  logic        We3_i,
    input  logic [31:0] Wd3_i,
    output logic [31:0] Rd1_o,
    output logic [31:0] Rd2_o
);

    logic [31:0] regs [32];

    // Falling edge write lets decode see the writeback value
    always_ff @(negedge clk) begin
        if (We3_i && A3_i != 5'd0)
            regs[A3_i] <= Wd3_i;
    end

    assign Rd1_o = (A1_i == 5'd0) ? 32'd0 : regs[A1_i];
    assign Rd2_o = (A2_i == 5'd0) ? 32'd0 : regs[A2_i];

endmodule

//--- rtl/rvAlu.sv
module rvAlu import rvPkg::*; (
    input  logic [31:0] A_i,
    input  logic [31:0] B_i,
    input  aluOpT       AluOp_i,
    output logic [31:0] Result_o,
    output logic        Zero_o
);

    always_comb begin
        unique case (AluOp_i)
            AluSub:  Result_o = A_i - B_i;
            AluAnd:  Result_o = A_i & B_i;
            AluOr:   Result_o = A_i | B_i;
            AluSlt:  Result_o = {31'd0, $signed(A_i) < $signed(B_i)};
            default: Result_o = A_i + B_i;
        endcase
    end

    assign Zero_o = (Result_o == 32'd0);   // Equality test for branches

endmodule

//--- rtl/rvPkg.sv
package rvPkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OpR      = 7'b0110011,
        OpI      = 7'b0010011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpLui    = 7'b0110111
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluAnd = 3'b010,
        AluOr  = 3'b011,
        AluSlt = 3'b101
    } aluOpT;

    typedef enum logic [2:0] {
        ImmI = 3'b000,
        ImmS = 3'b001,
        ImmB = 3'b010,
        ImmJ = 3'b011,
        ImmU = 3'b100
    } immSrcT;

    // Operand source for execute
    typedef enum logic [1:0] {
        FwdEx  = 2'b00, // Register file value
        FwdWb  = 2'b01,
        FwdMem = 2'b10
    } forwardT;

    typedef enum logic [1:0] {
        ResAlu     = 2'b00,
        ResMem     = 2'b01,
        ResPcPlus4 = 2'b10,
        ResImm     = 2'b11  // Upper immediate for lui
    } resultSrcT;

endpackage
